//--- Makefile
# Verilator simulation of the UART-to-SPI bridge.
TOP := bridge_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- bench/bridge_model.sv
/*
 * SPI bus monitor and MISO responder.
 * Samples the bus on falling clk edges, MISO moves 5 units after a rising edge.
 * One queued response per chip-select period, 8'h00 when none is queued.
 */

`default_nettype none

module bridge_model (
    input  logic clk_i,
    input  logic cs_n_i,
    input  logic sclk_i,
    input  logic mosi_i,
    output logic miso_o
);

    logic [7:0] resp_q[$];
    logic [7:0] mosi_q[$];
    int         rise_q[$];
    logic [7:0] resp;
    logic [7:0] shift;
    logic [2:0] bit_idx;
    int         rises;
    logic       cs_prev = 1'b1;
    logic       sclk_prev = 1'b0;
    logic       miso_next = 1'b0;

    initial miso_o = 1'b0;

    task automatic add_response(input logic [7:0] b);
        resp_q.push_back(b);
    endtask

    task automatic clear_all();
        resp_q.delete();
        mosi_q.delete();
        rise_q.delete();
    endtask

    always @(negedge clk_i) begin
        if (cs_prev && !cs_n_i) begin
            if (resp_q.size() > 0) begin
                resp = resp_q.pop_front();
            end else begin
                resp = 8'h00;
            end
            bit_idx   = 3'd7;
            rises     = 0;
            miso_next = resp[7];
        end else if (!cs_n_i && !sclk_prev && sclk_i) begin
            // Mode 0, MOSI holds while SCLK is high.
            shift = {shift[6:0], mosi_i};
            rises++;
        end else if (!cs_n_i && sclk_prev && !sclk_i && bit_idx != 3'd0) begin
            bit_idx--;
            miso_next = resp[bit_idx];
        end else if (!cs_prev && cs_n_i) begin
            mosi_q.push_back(shift);
            rise_q.push_back(rises);
            miso_next = 1'b0;
        end
        cs_prev   = cs_n_i;
        sclk_prev = sclk_i;
    end

    always @(posedge clk_i) begin
        #5;
        miso_o = miso_next;
    end

endmodule

`default_nettype wire

//--- bench/bridge_tb.sv
/*
 * Testbench for the UART-to-SPI bridge.
 * Payload and MISO bytes are random from a fixed seed.
 * Test 5 overruns the FIFO, so only an ordered subsequence comes out.
 */

`default_nettype none

`include "bridge_settings.svh"

module bridge_tb;

    localparam int UART_BYTE   = 10 * `BRIDGE_UART_DIV;
    localparam int SPI_BYTE    = 16 * `BRIDGE_SPI_HALF;
    localparam int GAP_CYCLES  = SPI_BYTE - UART_BYTE + 32;
    localparam int QUIET       = 2 * UART_BYTE;
    localparam int BURST       = 30;
    localparam int TOTAL_BYTES = 1 + 20 + 2 + BURST;
    localparam longint WATCHDOG =
        longint'(TOTAL_BYTES) * (UART_BYTE + SPI_BYTE + 8) * 100 * 2;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       uart_rx = 1'b1;
    logic       spi_miso;
    logic       spi_sclk;
    logic       spi_mosi;
    logic       spi_cs_n;
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       frame_err;
    logic       overflow;

    logic [7:0] sent_q[$];
    logic [7:0] exp_resp[$];
    int         errors = 0;
    int         failed_tests = 0;
    int         rx_count = 0;
    int         ferr_count = 0;
    int         test_start_errors = 0;
    logic       ovf_seen = 1'b0;

    always #50 clk = ~clk;

    uart_spi_bridge_top dut_i (
        .clk_i      (clk),
        .rst_i      (rst),
        .uart_rx_i  (uart_rx),
        .spi_miso_i (spi_miso),
        .spi_sclk_o (spi_sclk),
        .spi_mosi_o (spi_mosi),
        .spi_cs_n_o (spi_cs_n),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid),
        .frame_err_o(frame_err),
        .overflow_o (overflow)
    );

    bridge_model model_i (
        .clk_i (clk),
        .cs_n_i(spi_cs_n),
        .sclk_i(spi_sclk),
        .mosi_i(spi_mosi),
        .miso_o(spi_miso)
    );

    // ##################################################
    // Output monitors
    // ##################################################

    always @(negedge clk) begin
        logic [7:0] exp_b;
        if (!rst && rx_valid) begin
            rx_count++;
            assert (exp_resp.size() > 0) else begin
                $display("rx_valid_o pulsed with no response byte pending");
                errors++;
            end
            if (exp_resp.size() > 0) begin
                exp_b = exp_resp.pop_front();
                assert (rx_byte == exp_b) else begin
                    $display("ERROR: rx_byte_o expected %h got %h", exp_b, rx_byte);
                    errors++;
                end
            end
        end
        if (!rst && frame_err) begin
            ferr_count++;
        end
        // Overflow is sticky until reset.
        if (!rst && ovf_seen) begin
            assert (overflow) else begin
                $display("ERROR: overflow_o expected %h got %h", 1'b1, overflow);
                errors++;
            end
        end
        if (!rst && overflow) begin
            ovf_seen = 1'b1;
        end
    end

    // ##################################################
    // Stimulus and checks
    // ##################################################

    task automatic expect_level(input string name, input logic exp, input logic got);
        assert (got === exp) else begin
            $display("ERROR: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    function automatic logic [7:0] random_byte();
        logic [31:0] rnd;
        rnd = $urandom;
        return rnd[7:0];
    endfunction

    task automatic drive_bit(input logic b);
        @(posedge clk);
        #5;
        uart_rx = b;
        repeat (`BRIDGE_UART_DIV - 1) @(posedge clk);
    endtask

    task automatic send_uart_byte(input logic [7:0] b, input logic bad_stop);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(!bad_stop);
        // Back to idle after a low stop bit.
        if (bad_stop) begin
            drive_bit(1'b1);
        end
    endtask

    task automatic send_tracked(input logic [7:0] b);
        logic [7:0] r;
        r = random_byte();
        model_i.add_response(r);
        exp_resp.push_back(r);
        sent_q.push_back(b);
        send_uart_byte(b, 1'b0);
    endtask

    // Returns once the SPI side has been idle for QUIET cycles.
    task automatic wait_drain();
        int quiet;
        quiet = 0;
        while (quiet < QUIET) begin
            @(negedge clk);
            if (rx_valid || !spi_cs_n) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic start_test();
        model_i.clear_all();
        sent_q.delete();
        exp_resp.delete();
        rx_count = 0;
        test_start_errors = errors;
    endtask

    task automatic check_transfers(input logic exact);
        int i;
        int si;
        int n;
        n = model_i.mosi_q.size();
        assert (rx_count == n) else begin
            $display("%0d rx_valid_o strobes for %0d SPI transfers", rx_count, n);
            errors++;
        end
        for (i = 0; i < n; i++) begin
            assert (model_i.rise_q[i] == 8) else begin
                $display("Transfer %0d had %0d rising SCLK edges instead of 8",
                         i, model_i.rise_q[i]);
                errors++;
            end
        end
        if (exact) begin
            assert (n == sent_q.size()) else begin
                $display("%0d SPI transfers for %0d sent bytes", n, sent_q.size());
                errors++;
            end
            for (i = 0; i < n && i < sent_q.size(); i++) begin
                assert (model_i.mosi_q[i] == sent_q[i]) else begin
                    $display("ERROR: spi_mosi_o byte %0d expected %h got %h",
                             i, sent_q[i], model_i.mosi_q[i]);
                    errors++;
                end
            end
        end else begin
            // Dropped bytes leave gaps. Order must still hold.
            si = 0;
            for (i = 0; i < n; i++) begin
                while (si < sent_q.size() && sent_q[si] != model_i.mosi_q[i]) begin
                    si++;
                end
                assert (si < sent_q.size()) else begin
                    $display("MOSI byte %0d (%h) is out of order or was never sent",
                             i, model_i.mosi_q[i]);
                    errors++;
                end
                si++;
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_start_errors) begin
            $display("Test %0d %s: pass", num, name);
        end else begin
            $display("Test %0d %s: FAIL, %0d errors", num, name, errors - test_start_errors);
            failed_tests++;
        end
    endtask

    initial begin
        int          i;
        int          ferr_before;
        void'($urandom(32'h6dcf));
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        start_test();
        @(negedge clk);
        expect_level("spi_cs_n_o", 1'b1, spi_cs_n);
        expect_level("spi_sclk_o", 1'b0, spi_sclk);
        expect_level("rx_valid_o", 1'b0, rx_valid);
        expect_level("frame_err_o", 1'b0, frame_err);
        expect_level("overflow_o", 1'b0, overflow);
        repeat (QUIET) begin
            @(negedge clk);
            expect_level("spi_cs_n_o", 1'b1, spi_cs_n);
        end
        end_test(1, "reset state");

        start_test();
        send_tracked(random_byte());
        wait_drain();
        check_transfers(1'b1);
        end_test(2, "single byte");

        // Each UART byte plus gap outlasts one SPI byte.
        start_test();
        for (i = 0; i < 20; i++) begin
            send_tracked(random_byte());
            repeat (GAP_CYCLES) @(posedge clk);
        end
        wait_drain();
        check_transfers(1'b1);
        expect_level("overflow_o", 1'b0, overflow);
        end_test(3, "spaced random bytes");

        start_test();
        ferr_before = ferr_count;
        send_uart_byte(random_byte(), 1'b1);
        wait_drain();
        assert (ferr_count == ferr_before + 1) else begin
            $display("frame_err_o pulsed %0d times for one bad frame", ferr_count - ferr_before);
            errors++;
        end
        assert (model_i.mosi_q.size() == 0) else begin
            $display("A frame with a low stop bit started an SPI transfer");
            errors++;
        end
        send_tracked(random_byte());
        wait_drain();
        check_transfers(1'b1);
        end_test(4, "framing error");

        start_test();
        for (i = 0; i < BURST; i++) begin
            send_tracked(random_byte());
        end
        wait_drain();
        check_transfers(1'b0);
        assert (model_i.mosi_q.size() >= `BRIDGE_FIFO_DEPTH && model_i.mosi_q.size() < BURST)
        else begin
            $display("%0d of %0d burst bytes reached MOSI", model_i.mosi_q.size(), BURST);
            errors++;
        end
        expect_level("overflow_o", 1'b1, overflow);
        end_test(5, "FIFO overflow");

        $display("Tests run: 5, failed: %0d, check errors: %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: the run did not complete within %0d time units", WATCHDOG);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/bridge_pkg.sv
/*
 * Shared types of the bridge.
 * State encodings only, the widths are fixed to 2 and 3 bits.
 */

`default_nettype none

package bridge_pkg;

    // UART receiver states.
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

    // SPI master states.
    typedef enum logic [2:0] {
        SPI_IDLE     = 3'd0,
        SPI_LOAD     = 3'd1,
        SPI_SHIFT_LO = 3'd2,
        SPI_SHIFT_HI = 3'd3,
        SPI_DONE     = 3'd4
    } spi_state_e;

endpackage

`default_nettype wire

//--- logic/bridge_settings.svh
/*
 * Build-time constants of the UART-to-SPI bridge.
 * All periods are in system clock cycles. Nothing here is run-time configurable.
 * UART_DIV must be at least 4. SPI_HALF must be at least 2.
 * FIFO_DEPTH must be a power of two, at least 2.
 */

`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// UART bit period.
`define BRIDGE_UART_DIV 16

// Half of one SPI clock period.
`define BRIDGE_SPI_HALF 16

// Entries in the byte FIFO.
`define BRIDGE_FIFO_DEPTH 8

`endif

//--- logic/byte_fifo.sv
/*
 * Circular byte FIFO with register storage.
 * DEPTH must be a power of two, at least 2.
 * A push while full is discarded and sets overflow_o until reset.
 * pop while empty is ignored.
 */

`default_nettype none

module byte_fifo #(
    parameter int DEPTH = 8
) (
    input  logic        clk_i,
    input  logic        rst_i,
    byte_queue_if.queue q,
    output logic        overflow_o
);

    localparam int AW = $clog2(DEPTH);

    logic [7:0]  mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        wr_en;
    logic        rd_en;

    // Extra pointer bit tells full from empty.
    assign q.empty = (wr_ptr == rd_ptr);
    assign q.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr_en = q.push && !q.full;
    assign rd_en = q.pop && !q.empty;

    // Head entry, seen in the same cycle as pop.
    assign q.pop_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= q.push_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Sticky.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            overflow_o <= 1'b0;
        end else if (q.push && q.full) begin
            overflow_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/byte_queue_if.sv
/*
 * Write and read sides of the byte FIFO.
 * push and pop are one-cycle strobes. pop_data is the head entry,
 * valid in the same cycle as pop. No clock travels with it.
 */

`default_nettype none

interface byte_queue_if;

    logic       push;
    logic [7:0] push_data;
    logic       full;

    logic       pop;
    logic [7:0] pop_data;
    logic       empty;

    modport writer (output push, output push_data, input full);

    modport reader (output pop, input pop_data, input empty);

    modport queue (
        input  push, push_data, pop,
        output full, pop_data, empty
    );

endinterface

`default_nettype wire

//--- logic/spi_master.sv
/*
 * SPI master, mode 0, MSB first, one byte per chip select.
 * SCLK is low then high for BRIDGE_SPI_HALF cycles per bit.
 * MISO is sampled as SCLK rises and is expected synchronous to clk_i.
 * The received byte appears on rx_byte_o with a one-cycle rx_valid_o.
 */

`default_nettype none

`include "bridge_settings.svh"

module spi_master (
    input  logic         clk_i,
    input  logic         rst_i,
    byte_queue_if.reader q,
    input  logic         miso_i,
    output logic         sclk_o,
    output logic         mosi_o,
    output logic         cs_n_o,
    output logic [7:0]   rx_byte_o,
    output logic         rx_valid_o
);

    import bridge_pkg::*;

    localparam int HALF = `BRIDGE_SPI_HALF;
    localparam int CW   = $clog2(HALF);

    localparam logic [CW-1:0] HALF_LAST = CW'(HALF - 1);

    spi_state_e    state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    tx_shift;
    logic [7:0]    rx_shift;
    logic          lo_end;
    logic          hi_end;

    // Pop only from idle.
    assign q.pop = (state == SPI_IDLE) && !q.empty;

    assign lo_end = (state == SPI_SHIFT_LO) && (cnt == HALF_LAST);
    assign hi_end = (state == SPI_SHIFT_HI) && (cnt == HALF_LAST);

    // ##################################################
    // Transfer FSM
    // ##################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= SPI_IDLE;
            cnt        <= '0;
            bit_cnt    <= '0;
            sclk_o     <= 1'b0;
            mosi_o     <= 1'b0;
            cs_n_o     <= 1'b1;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            case (state)
                SPI_IDLE: begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    if (q.pop) begin
                        cs_n_o <= 1'b0;
                        state  <= SPI_LOAD;
                    end
                end
                SPI_LOAD: begin
                    mosi_o <= tx_shift[7];
                    state  <= SPI_SHIFT_LO;
                end
                SPI_SHIFT_LO: begin
                    if (lo_end) begin
                        cnt    <= '0;
                        sclk_o <= 1'b1;
                        state  <= SPI_SHIFT_HI;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SPI_SHIFT_HI: begin
                    if (hi_end) begin
                        cnt    <= '0;
                        sclk_o <= 1'b0;
                        if (bit_cnt == 3'd7) begin
                            cs_n_o <= 1'b1;
                            mosi_o <= 1'b0;
                            state  <= SPI_DONE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            mosi_o  <= tx_shift[6];
                            state   <= SPI_SHIFT_LO;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SPI_DONE: begin
                    rx_valid_o <= 1'b1;
                    state      <= SPI_IDLE;
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // ##################################################
    // Shift registers
    // ##################################################

    always_ff @(posedge clk_i) begin
        if (q.pop) begin
            tx_shift <= q.pop_data;
        end else if (hi_end) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
        if (lo_end) begin
            rx_shift <= {rx_shift[6:0], miso_i};
        end
        if (state == SPI_DONE) begin
            rx_byte_o <= rx_shift;
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
/*
 * UART receiver, 8N1, fixed bit period of BRIDGE_UART_DIV cycles.
 * Cannot be stalled; full on the queue is not honoured here, the FIFO drops.
 * A start bit that is high again at mid-bit is ignored as a glitch.
 * A low stop bit discards the byte and pulses frame_err_o.
 */

`default_nettype none

`include "bridge_settings.svh"

module uart_rx (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         rx_i,
    byte_queue_if.writer q,
    output logic         frame_err_o
);

    import bridge_pkg::*;

    localparam int DIV = `BRIDGE_UART_DIV;
    localparam int CW  = $clog2(DIV);

    localparam logic [CW-1:0] HALF_LAST = CW'(DIV / 2 - 1);
    localparam logic [CW-1:0] FULL_LAST = CW'(DIV - 1);

    rx_state_e     state;
    logic          rx_meta;
    logic          rx_sync;
    logic          rx_prev;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shreg;
    logic          push_q;

    assign q.push      = push_q;
    assign q.push_data = shreg;

    // ##################################################
    // Input synchronizer
    // ##################################################

    // Idle line is high.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // ##################################################
    // Frame FSM
    // ##################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_cnt     <= '0;
            push_q      <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            push_q      <= 1'b0;
            frame_err_o <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == HALF_LAST) begin
                        cnt   <= '0;
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == FULL_LAST) begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == FULL_LAST) begin
                        cnt   <= '0;
                        state <= RX_IDLE;
                        if (rx_sync) begin
                            push_q <= 1'b1;
                        end else begin
                            frame_err_o <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && cnt == FULL_LAST) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_spi_bridge_top.sv
/*
 * UART-to-SPI bridge top level.
 * Bytes received on uart_rx_i are queued and sent one per SPI transfer.
 * Single chip select, build-time timing only.
 */

`default_nettype none

`include "bridge_settings.svh"

module uart_spi_bridge_top (
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       uart_rx_i,

    input  logic       spi_miso_i,
    output logic       spi_sclk_o,
    output logic       spi_mosi_o,
    output logic       spi_cs_n_o,

    output logic [7:0] rx_byte_o,
    output logic       rx_valid_o,
    output logic       frame_err_o,
    output logic       overflow_o
);

    byte_queue_if queue ();

    uart_rx i_uart_rx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rx_i       (uart_rx_i),
        .q          (queue.writer),
        .frame_err_o(frame_err_o)
    );

    byte_fifo #(.DEPTH(`BRIDGE_FIFO_DEPTH)) i_byte_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .q         (queue.queue),
        .overflow_o(overflow_o)
    );

    spi_master i_spi_master (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .q         (queue.reader),
        .miso_i    (spi_miso_i),
        .sclk_o    (spi_sclk_o),
        .mosi_o    (spi_mosi_o),
        .cs_n_o    (spi_cs_n_o),
        .rx_byte_o (rx_byte_o),
        .rx_valid_o(rx_valid_o)
    );

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/bridge_pkg.sv
logic/byte_queue_if.sv
logic/uart_rx.sv
logic/byte_fifo.sv
logic/spi_master.sv
logic/uart_spi_bridge_top.sv
bench/bridge_model.sv
bench/bridge_tb.sv
